/* tests/encoderTests.mem */
// record: length, symbols ending with 100 (EOF), word count, expected words, last byte count
// a zero length ends the list
00000001 00000100 00000001 000000FF 00000002
00000004 000000FF 00000000 000000FF 00000100
00000001 E0EF007F 00000004
00000005 000000FF 00000000 000000FF 00000000 00000100
00000002 C4AF007F 0000007D 00000001
00000006 00000000 00000000 00000000 00000000 00000000 00000100
00000002 00000000 0000000E 00000002
00000001 00000100 00000001 000000FF 00000002
00000000

/* tb.f */
+incdir+src
src/codecPkg.sv
src/codecIfs.sv
src/freqModel.sv
src/seqDivider.sv
src/bitPacker.sv
src/encoderCore.sv
src/arithEncoder.sv
tests/tbArithEncoder.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tbArithEncoder
FILELIST = tb.f
OBJDIR   = obj_dir

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* tests/tbArithEncoder.sv */
// self-checking testbench for arithEncoder, replays the messages and expected words of the test file
`timescale 1ns/1ps

module tbArithEncoder;
    import codecPkg::*;

    logic       clk;
    logic       rstn;
    logic       start;
    symbol_t    symbolIn;
    logic       symbolProvided;
    logic       readSuccess;
    logic       idle;
    logic       symbolRequested;
    logic       resultReady;
    byteCount_t validOutputBytes;
    word_t      out;

    logic [31:0] testData [0:255];   // flat records, a zero length ends the list
    symbol_t     msgSymbols [0:63];
    word_t       msgWords [0:7];
    int          watchLimit = 0;

    arithEncoder uut (
        .clk            (clk),
        .rstn           (rstn),
        .start          (start),
        .symbolIn       (symbolIn),
        .symbolProvided (symbolProvided),
        .readSuccess    (readSuccess),
        .idle           (idle),
        .symbolRequested(symbolRequested),
        .resultReady    (resultReady),
        .validOutputBytes(validOutputBytes),
        .out            (out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkWord(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, expected, actual);
            stopWithFailure("output word mismatch");
        end
    endtask

    task automatic checkBytes(input string name, input byteCount_t expected,
                              input byteCount_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %0t %s expected %0d actual %0d", $time, name, expected, actual);
            stopWithFailure("byte count mismatch");
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("[ERROR] %0t %s expected %b actual %b", $time, name, expected, actual);
            stopWithFailure("control level mismatch");
        end
    endtask

    task automatic hostDelay();
        repeat ($urandom_range(5, 0)) @(posedge clk);
    endtask

    // symbol host, answers each request with the next symbol of the message
    task automatic feedSymbols(input int count);
        for (int k = 1; k < count; k++) begin
            do @(negedge clk); while (!symbolRequested);
            hostDelay();
            @(posedge clk);
            symbolIn <= msgSymbols[k];
            symbolProvided <= 1'b1;
            do @(negedge clk); while (symbolRequested);
            hostDelay();
            @(posedge clk);
            symbolProvided <= 1'b0;
        end
    endtask

    // result host, checks every word and its byte count before acknowledging it
    task automatic readWords(input int count, input byteCount_t lastBytes);
        for (int w = 0; w < count; w++) begin
            do @(negedge clk); while (!resultReady);
            checkWord("out", msgWords[w], out);
            checkBytes("validOutputBytes", (w == count - 1) ? lastBytes : byteCount_t'(4),
                       validOutputBytes);
            hostDelay();
            @(posedge clk);
            readSuccess <= 1'b1;
            do @(negedge clk); while (resultReady);
            hostDelay();
            @(posedge clk);
            readSuccess <= 1'b0;
        end
    endtask

    // a request must never be open while a word is still unread
    always @(negedge clk) begin
        if (rstn && symbolRequested) begin
            checkFlag("resultReady during symbol request", 1'b0, resultReady);
        end
    end

    initial begin
        wait (watchLimit != 0);
        repeat (watchLimit) @(posedge clk);
        $display("timeout: the encoder did not finish the messages in time");
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        int         seedValue;
        int         ptr;
        int         msgLen;
        int         numWords;
        int         totalSymbols;
        int         msgCount;
        byteCount_t lastBytes;

        start = 1'b0;
        symbolIn = '0;
        symbolProvided = 1'b0;
        readSuccess = 1'b0;
        rstn = 1'b0;
        seedValue = $urandom(96);
        $readmemh("tests/encoderTests.mem", testData);

        ptr = 0;
        totalSymbols = 0;
        while (testData[ptr] != 0) begin
            totalSymbols += testData[ptr];
            ptr += testData[ptr] + testData[ptr + testData[ptr] + 1] + 3;
        end
        watchLimit = 200 * totalSymbols + 2000;

        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        @(negedge clk);
        checkFlag("idle", 1'b1, idle);
        checkFlag("resultReady", 1'b0, resultReady);
        checkFlag("symbolRequested", 1'b0, symbolRequested);

        ptr = 0;
        msgCount = 0;
        while (testData[ptr] != 0) begin
            msgLen = testData[ptr];
            for (int k = 0; k < msgLen; k++) begin
                msgSymbols[k] = symbol_t'(testData[ptr + 1 + k]);
            end
            numWords = testData[ptr + msgLen + 1];
            for (int w = 0; w < numWords; w++) begin
                msgWords[w] = testData[ptr + msgLen + 2 + w];
            end
            lastBytes = byteCount_t'(testData[ptr + msgLen + 2 + numWords]);
            ptr += msgLen + numWords + 3;

            do @(negedge clk); while (!idle);
            @(posedge clk);
            start <= 1'b1;
            symbolIn <= msgSymbols[0];
            @(posedge clk);
            start <= 1'b0;
            fork
                feedSymbols(msgLen);
                readWords(numWords, lastBytes);
            join
            do @(negedge clk); while (!idle);    // end of message
            checkFlag("resultReady", 1'b0, resultReady);
            checkFlag("symbolRequested", 1'b0, symbolRequested);
            msgCount++;
        end

        if (msgCount == 0) begin
            stopWithFailure("no messages were read from the test file");
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

endmodule

/* src/arithEncoder.sv */
// top level of the adaptive arithmetic encoder, plain host ports around core, model, divider, packer
`timescale 1ns/1ps

module arithEncoder (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 start,
    input  codecPkg::symbol_t    symbolIn,
    input  logic                 symbolProvided,
    input  logic                 readSuccess,
    output logic                 idle,
    output logic                 symbolRequested,
    output logic                 resultReady,
    output codecPkg::byteCount_t validOutputBytes,
    output codecPkg::word_t      out
);

    modelIf modelBus ();
    divIf   divBus ();
    bitIf   bitBus ();

    encoderCore encCore (
        .clk            (clk),
        .rstn           (rstn),
        .start          (start),
        .symbolIn       (symbolIn),
        .symbolProvided (symbolProvided),
        .idle           (idle),
        .symbolRequested(symbolRequested),
        .model          (modelBus.core),
        .div            (divBus.core),
        .bits           (bitBus.core)
    );

    freqModel freqTable (
        .clk  (clk),
        .rstn (rstn),
        .model(modelBus.model)
    );

    seqDivider divider (
        .clk (clk),
        .rstn(rstn),
        .div (divBus.divider)
    );

    bitPacker packer (
        .clk             (clk),
        .rstn            (rstn),
        .bits            (bitBus.packer),
        .readSuccess     (readSuccess),
        .resultReady     (resultReady),
        .validOutputBytes(validOutputBytes),
        .out             (out)
    );

endmodule

/* src/encoderCore.sv */
// encoder FSM: subinterval arithmetic, interval expansion, pending bits and end-of-message flush
`timescale 1ns/1ps
`include "codecMacros.svh"

module encoderCore (
    input  logic              clk,
    input  logic              rstn,
    input  logic              start,
    input  codecPkg::symbol_t symbolIn,
    input  logic              symbolProvided,
    output logic              idle,
    output logic              symbolRequested,
    modelIf.core              model,
    divIf.core                div,
    bitIf.core                bits
);
    import codecPkg::*;

    localparam bound_t  whole = bound_t'(`WHOLE);
    localparam bound_t  half = bound_t'(`HALF);
    localparam bound_t  quarter = bound_t'(`QUARTER);
    localparam bound_t  threeQuarters = bound_t'(`THREE_QUARTERS);
    localparam symbol_t eofSymbol = symbol_t'(`EOF_SYMBOL);

    encState_t             state;
    bound_t                low;
    bound_t                high;
    bound_t                width;
    prod_t                 prodLow;       // kept for the second division
    logic [`PRECISION-1:0] pending;       // opposite bits owed after the next decided bit
    symbol_t               curSymbol;
    logic                  lastSymbol;
    logic                  pendValue;
    logic                  expandLow;
    logic                  expandHigh;
    logic                  expandMid;

    assign expandLow = high < half;
    assign expandHigh = low > half;
    assign expandMid = (low > quarter) && (high < threeQuarters);

    assign model.symbol = curSymbol;
    assign model.clearModel = (state == IDLE) && start;
    assign model.bumpModel = (state == UPDATE_MODEL);
    assign bits.clearWord = (state == IDLE) && start;

    // bits leave combinationally so a full packer stops them in the same cycle
    always_comb begin
        bits.bitValid = 1'b0;
        bits.bitValue = 1'b0;
        bits.lastBit = 1'b0;
        if (!bits.full) begin
            case (state)
                RESCALE: begin
                    bits.bitValid = expandLow || expandHigh;
                    bits.bitValue = !expandLow;
                end
                EMIT_PENDING: begin
                    bits.bitValid = 1'b1;
                    bits.bitValue = pendValue;
                    bits.lastBit = lastSymbol && (pending == 1);
                end
                FLUSH: begin
                    bits.bitValid = 1'b1;
                    bits.bitValue = low > quarter;
                end
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
            idle <= 1'b1;
            symbolRequested <= 1'b0;
            div.startDiv <= 1'b0;
            pending <= '0;
            lastSymbol <= 1'b0;
        end else begin
            div.startDiv <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        curSymbol <= symbolIn;
                        low <= '0;
                        high <= whole;
                        width <= whole;
                        pending <= '0;
                        lastSymbol <= 1'b0;
                        idle <= 1'b0;
                        state <= SCALE_MUL;
                    end
                end
                SCALE_MUL: begin
                    div.dividend <= width * model.cumHigh;
                    div.divisor <= model.total;
                    div.startDiv <= 1'b1;
                    prodLow <= width * model.cumLow;
                    state <= DIV_HIGH;
                end
                DIV_HIGH: begin
                    if (div.doneDiv) begin
                        high <= low + div.quotient[`PRECISION:0];
                        div.dividend <= prodLow;
                        div.startDiv <= 1'b1;
                        state <= DIV_LOW;
                    end
                end
                DIV_LOW: begin
                    if (div.doneDiv) begin
                        low <= low + div.quotient[`PRECISION:0];
                        state <= RESCALE;
                    end
                end
                RESCALE: begin
                    if (!bits.full) begin
                        if (expandLow || expandHigh) begin
                            pendValue <= expandLow;
                            low <= expandLow ? low << 1 : (low - half) << 1;
                            high <= expandLow ? high << 1 : (high - half) << 1;
                            if (pending != 0) begin
                                state <= EMIT_PENDING;
                            end
                        end else if (expandMid) begin
                            low <= (low - quarter) << 1;
                            high <= (high - quarter) << 1;
                            pending <= pending + 1'b1;
                        end else if (curSymbol == eofSymbol) begin
                            lastSymbol <= 1'b1;
                            pending <= pending + 1'b1;  // flush always owes one more
                            state <= FLUSH;
                        end else begin
                            state <= UPDATE_MODEL;
                        end
                    end
                end
                EMIT_PENDING: begin
                    if (!bits.full) begin
                        pending <= pending - 1'b1;
                        if (pending == 1) begin
                            state <= lastSymbol ? DONE : RESCALE;
                        end
                    end
                end
                FLUSH: begin
                    if (!bits.full) begin
                        pendValue <= (low <= quarter);
                        state <= EMIT_PENDING;
                    end
                end
                UPDATE_MODEL: begin
                    width <= high - low;
                    symbolRequested <= 1'b1;
                    state <= WAIT_SYMBOL;
                end
                WAIT_SYMBOL: begin
                    if (symbolRequested && symbolProvided) begin
                        curSymbol <= symbolIn;
                        symbolRequested <= 1'b0;
                    end else if (!symbolRequested && !symbolProvided) begin
                        state <= SCALE_MUL;     // host released its strobe
                    end
                end
                DONE: begin
                    if (!bits.full) begin       // last word has been read
                        idle <= 1'b1;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!rstn) (state == EMIT_PENDING) |-> (pending != 0))
        else $error("pending bit emitted while none is owed");

    assert property (@(posedge clk) disable iff (!rstn) !(symbolRequested && idle))
        else $error("symbol requested while the encoder is idle");

endmodule

/* src/bitPacker.sv */
// packs emitted bits LSB first into 32-bit words and holds each until the host reads it
`timescale 1ns/1ps
`include "codecMacros.svh"

module bitPacker (
    input  logic                 clk,
    input  logic                 rstn,
    bitIf.packer                 bits,
    input  logic                 readSuccess,
    output logic                 resultReady,
    output codecPkg::byteCount_t validOutputBytes,
    output codecPkg::word_t      out
);
    import codecPkg::*;

    logic [`BITPOS_W-1:0] bitPos;
    word_t                word;
    logic                 releaseWait;    // read done, waiting for readSuccess to drop

    assign bits.full = resultReady || releaseWait;
    assign out = word;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            bitPos <= '0;
            word <= '0;
            resultReady <= 1'b0;
            releaseWait <= 1'b0;
            validOutputBytes <= 3'd4;
        end else if (bits.clearWord) begin
            bitPos <= '0;
            word <= '0;
        end else if (resultReady) begin
            if (readSuccess) begin
                resultReady <= 1'b0;
                releaseWait <= 1'b1;
                word <= '0;
                bitPos <= '0;
            end
        end else if (releaseWait) begin
            if (!readSuccess) begin
                releaseWait <= 1'b0;
            end
        end else if (bits.bitValid) begin
            word[bitPos] <= bits.bitValue;
            bitPos <= bitPos + 1'b1;
            validOutputBytes <= byteCount_t'(bitPos[`BITPOS_W-1:3]) + 1'b1;  // bytes touched
            resultReady <= (bitPos == '1) || bits.lastBit;
        end
    end

endmodule

/* src/seqDivider.sv */
// restoring divider, one quotient bit per cycle, scales the products into subinterval offsets
`timescale 1ns/1ps
`include "codecMacros.svh"

module seqDivider (
    input logic   clk,
    input logic   rstn,
    divIf.divider div
);
    import codecPkg::*;

    localparam int StepW = $clog2(`PROD_W);

    freq_t            remReg;     // partial remainder
    prod_t            quoReg;     // dividend bits leave at the top, quotient bits enter below
    logic [StepW-1:0] step;       // steps already done
    logic             busy;
    freq_t            remIn;
    prod_t            quoIn;
    logic [`FREQ_W:0] trial;
    logic [`FREQ_W:0] diff;

    // the first step runs on the start edge itself
    always_comb begin
        remIn = div.startDiv ? '0 : remReg;
        quoIn = div.startDiv ? div.dividend : quoReg;
        trial = {remIn, quoIn[`PROD_W-1]};
        diff = trial - {1'b0, div.divisor};
    end

    always_ff @(posedge clk) begin
        if (div.startDiv || busy) begin
            if (!diff[`FREQ_W]) begin           // trial fits, subtract
                remReg <= diff[`FREQ_W-1:0];
                quoReg <= {quoIn[`PROD_W-2:0], 1'b1};
            end else begin
                remReg <= trial[`FREQ_W-1:0];
                quoReg <= {quoIn[`PROD_W-2:0], 1'b0};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            busy <= 1'b0;
            step <= '0;
            div.doneDiv <= 1'b0;
        end else begin
            div.doneDiv <= 1'b0;
            if (div.startDiv) begin
                busy <= 1'b1;
                step <= StepW'(1);
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == StepW'(`PROD_W - 1)) begin
                    busy <= 1'b0;           // last bit lands now
                    div.doneDiv <= 1'b1;
                end
            end
        end
    end

    assign div.quotient = quoReg;

    assert property (@(posedge clk) disable iff (!rstn) div.startDiv |-> !busy)
        else $error("division started while another one is running");

endmodule

/* src/freqModel.sv */
// adaptive cumulative frequency table, cleared to uniform and bumped after each coded symbol
`timescale 1ns/1ps
`include "codecMacros.svh"

module freqModel (
    input logic   clk,
    input logic   rstn,
    modelIf.model model
);
    import codecPkg::*;

    freq_t freqBegin [0:`NUM_SYMBOLS-1];
    freq_t freqEnd [0:`NUM_SYMBOLS-1];
    freq_t totalCount;

    always_ff @(posedge clk) begin
        if (!rstn || model.clearModel) begin
            for (int i = 0; i < `NUM_SYMBOLS; i++) begin
                freqBegin[i] <= freq_t'(i);       // symbol i covers [i, i+1)
                freqEnd[i] <= freq_t'(i + 1);
            end
            totalCount <= freq_t'(`NUM_SYMBOLS);
        end else if (model.bumpModel) begin
            for (int i = 0; i < `NUM_SYMBOLS; i++) begin
                if (i > model.symbol) begin
                    freqBegin[i] <= freqBegin[i] + 1'b1;
                end
                if (i >= model.symbol) begin
                    freqEnd[i] <= freqEnd[i] + 1'b1;  // own end and everything above
                end
            end
            totalCount <= totalCount + 1'b1;
        end
    end

    assign model.cumLow = freqBegin[model.symbol];
    assign model.cumHigh = freqEnd[model.symbol];
    assign model.total = totalCount;

    // no halving here, so a message long enough to need it is an error
    assert property (@(posedge clk) disable iff (!rstn) totalCount < freq_t'(`QUARTER - 1))
        else $error("frequency total reached the halving threshold");

endmodule

/* src/codecIfs.sv */
// bundles joining the encoder core to its frequency model, divider and bit packer
`timescale 1ns/1ps

interface modelIf;
    import codecPkg::*;

    symbol_t symbol;
    logic    clearModel;    // restore uniform counts
    logic    bumpModel;     // count the coded symbol once more
    freq_t   cumLow;
    freq_t   cumHigh;
    freq_t   total;

    modport core (output symbol, clearModel, bumpModel, input cumLow, cumHigh, total);
    modport model (input symbol, clearModel, bumpModel, output cumLow, cumHigh, total);
endinterface

interface divIf;
    import codecPkg::*;

    prod_t dividend;
    freq_t divisor;
    logic  startDiv;
    prod_t quotient;       // held until the next start
    logic  doneDiv;

    modport core (output dividend, divisor, startDiv, input quotient, doneDiv);
    modport divider (input dividend, divisor, startDiv, output quotient, doneDiv);
endinterface

interface bitIf;
    logic bitValid;
    logic bitValue;
    logic lastBit;         // closes the partial word
    logic clearWord;
    logic full;            // word waiting for the host

    modport core (output bitValid, bitValue, lastBit, clearWord, input full);
    modport packer (input bitValid, bitValue, lastBit, clearWord, output full);
endinterface

/* src/codecPkg.sv */
// types shared by the encoder RTL, imported by each file that uses them
`include "codecMacros.svh"

package codecPkg;

    typedef logic [`SYM_W-1:0]   symbol_t;
    typedef logic [`FREQ_W-1:0]  freq_t;
    typedef logic [`PRECISION:0] bound_t;     // wide enough to hold WHOLE
    typedef logic [`PROD_W-1:0]  prod_t;
    typedef logic [`WORD_W-1:0]  word_t;
    typedef logic [2:0]          byteCount_t;

    typedef enum logic [3:0] {
        IDLE,
        SCALE_MUL,
        DIV_HIGH,
        DIV_LOW,
        RESCALE,
        EMIT_PENDING,
        WAIT_SYMBOL,
        UPDATE_MODEL,
        FLUSH,
        DONE
    } encState_t;

endpackage

/* src/codecMacros.svh */
// widths and constants of the arithmetic encoder, included by the package and the RTL
`ifndef CODEC_MACROS_SVH
`define CODEC_MACROS_SVH

`define PRECISION       16
`define NUM_SYMBOLS     257
`define EOF_SYMBOL      256
`define SYM_W           9
`define FREQ_W          13
`define WORD_W          32
`define BITPOS_W        5

// interval boundaries, the whole range is 2^(PRECISION-1)
`define WHOLE           (1 << (`PRECISION - 1))
`define HALF            (1 << (`PRECISION - 2))
`define QUARTER         (1 << (`PRECISION - 3))
`define THREE_QUARTERS  (3 << (`PRECISION - 3))

// interval width times a cumulative frequency
`define PROD_W          (`PRECISION + 1 + `FREQ_W)

`endif
